// ==== tb.f ====
rtl/video_pkg.sv
rtl/palette_writer.sv
rtl/palette_ram.sv
rtl/video_blend.sv
rtl/video_out.sv
rtl/compositor_top.sv
test/tb_compositor.sv
+incdir+test

// ==== Makefile ====
SRCS := $(wildcard rtl/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run clean

all: obj_dir/Vtb_compositor

obj_dir/Vtb_compositor: $(SRCS) tb.f
	verilator --binary --timing -j 0 -f tb.f --top-module tb_compositor -o Vtb_compositor

run: obj_dir/Vtb_compositor
	obj_dir/Vtb_compositor

clean:
	rm -rf obj_dir

// ==== test/tb_compositor_model.svh ====
// reference model, included inside tb_compositor

// host view of both palette tables
// an accepted write lands here one cycle after its handshake, like the RAM
video_pkg::argb_t pal_img [video_pkg::PAL_DEPTH];

logic [31:0] lcg_state = 32'd36957;

function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16]; // upper bits have the longer period
endfunction

function automatic int rand_below(input int n);
    return int'(rand16()) % n;
endfunction

function automatic logic [video_pkg::PAL_IDX_W-1:0] rand_idx();
    logic [15:0] v;
    v = rand16();
    return v[11:4];
endfunction

function automatic video_pkg::argb_t rand_argb();
    return video_pkg::argb_t'(rand16());
endfunction

// one channel, worked in plain integers
function automatic logic [3:0] mix_channel(
    input video_pkg::blend_mode_e mode,
    input logic [1:0]             amount,
    input int                     a,
    input int                     b
);
    int r;
    case (mode)
        video_pkg::BLEND_B_ALPHA: begin
            case (amount)
                2'd0:    r = a;
                2'd1:    r = (3 * a + b) / 4; // 75 percent A, rounded down
                2'd2:    r = (a + b) / 2;
                default: r = b;
            endcase
        end
        video_pkg::BLEND_WRAP:  r = (a + b) % 16;
        video_pkg::BLEND_CLAMP: r = (a + b > 15) ? 15 : a + b;
        default:                r = a;
    endcase
    return r[3:0];
endfunction

function automatic video_pkg::rgb_t blend_ref(
    input video_pkg::argb_t a,
    input video_pkg::argb_t b
);
    video_pkg::blend_mode_e mode;
    logic [1:0]             amount;
    video_pkg::rgb_t        res;
    mode   = video_pkg::blend_mode_e'(a.alpha[3:2]);
    amount = b.alpha[3:2];
    res.r  = mix_channel(mode, amount, int'(a.rgb.r), int'(b.rgb.r));
    res.g  = mix_channel(mode, amount, int'(a.rgb.g), int'(b.rgb.g));
    res.b  = mix_channel(mode, amount, int'(a.rgb.b), int'(b.rgb.b));
    return res;
endfunction

// what the DUT should show three cycles after this pixel goes in
function automatic video_pkg::pixel_out_t expect_pixel(input video_pkg::pixel_in_t p);
    video_pkg::pixel_out_t e;
    e.timing = p.timing;
    if (p.timing.de) begin
        e.rgb = blend_ref(pal_img[{1'b0, p.idx_a}], pal_img[{1'b1, p.idx_b}]);
    end else begin
        e.rgb = '0; // blanked
    end
    return e;
endfunction

// ==== test/tb_compositor.sv ====
`timescale 1ns/1ps

module tb_compositor;

    localparam int LINE_ACTIVE  = 64;
    localparam int LINE_BLANK   = 16;
    localparam int LINE_LEN     = LINE_ACTIVE + LINE_BLANK;
    localparam int RAND_LINES   = 24;
    localparam int TIMING_LINES = 8;
    localparam int REWRITES     = 64;
    // upper bound on stimulus cycles summed over the phases
    localparam int STIM_CYCLES  = 16 + 4 * video_pkg::PAL_DEPTH + 8 * REWRITES + 128
                                  + (RAND_LINES + TIMING_LINES) * LINE_LEN
                                  + 2 * LINE_LEN + 32 + 8;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES * 3 / 2;

    // directed pairs for the B-alpha amounts with a=b=15, the wrap and clamp edges and A on top
    localparam logic [15:0] DIR_A [10] = '{16'h0fff, 16'h0fff, 16'h0fff, 16'h0fff,
                                           16'h48f0, 16'h4f08, 16'h88f0, 16'h8f08,
                                           16'hc5a3, 16'hf0f0};
    localparam logic [15:0] DIR_B [10] = '{16'h0fff, 16'h4fff, 16'h8fff, 16'hcfff,
                                           16'h0810, 16'h0108, 16'h0810, 16'h0108,
                                           16'h7b2e, 16'hfff1};

    logic                  clk;
    logic                  rst_n_i;
    video_pkg::pixel_in_t  pix_i;
    logic                  pal_wr_valid_i;
    video_pkg::pal_wr_t    pal_wr_i;
    logic                  pal_wr_ready_o;
    video_pkg::pixel_out_t pix_o;

    logic                  wr_pending;   // host write waiting for ready
    video_pkg::pal_wr_t    wr_cur;
    logic                  staged_v;     // taken on the last edge and applied to the model next cycle
    video_pkg::pal_wr_t    staged;

    video_pkg::pixel_out_t exp_q [$];    // oldest first
    video_pkg::pixel_out_t exp_pix;
    logic                  check_en;
    int                    cycle_cnt = 0;

    `include "tb_compositor_model.svh"

    compositor_top dut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pix_i          (pix_i),
        .pal_wr_valid_i (pal_wr_valid_i),
        .pal_wr_i       (pal_wr_i),
        .pal_wr_ready_o (pal_wr_ready_o),
        .pix_o          (pix_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    function automatic video_pkg::pixel_in_t make_pixel(
        input logic hs,
        input logic vs,
        input logic de,
        input logic [video_pkg::PAL_IDX_W-1:0] a,
        input logic [video_pkg::PAL_IDX_W-1:0] b
    );
        video_pkg::pixel_in_t p;
        p.timing.hsync = hs;
        p.timing.vsync = vs;
        p.timing.de    = de;
        p.idx_a        = a;
        p.idx_b        = b;
        return p;
    endfunction

    function automatic video_pkg::pixel_in_t visible_pixel();
        return make_pixel(1'b0, 1'b0, 1'b1, rand_idx(), rand_idx());
    endfunction

    function automatic video_pkg::pixel_in_t blank_pixel();
        return make_pixel(1'b0, 1'b0, 1'b0, rand_idx(), rand_idx());
    endfunction

    // one clock of stimulus driven on the falling edge
    task automatic step(input video_pkg::pixel_in_t p);
        @(negedge clk);
        // host port as the last rising edge saw it
        check_equal("pal_wr_ready_o", {31'd0, pal_wr_ready_o}, {31'd0, ~pix_i.timing.de});
        if (staged_v) begin
            pal_img[staged.addr] = staged.data;
        end
        staged_v = pal_wr_valid_i && !pix_i.timing.de;
        staged   = pal_wr_i;
        if (staged_v) begin
            wr_pending = 1'b0;
        end
        pix_i          = p;
        pal_wr_valid_i = wr_pending;
        pal_wr_i       = wr_cur;
        exp_q.push_back(expect_pixel(p));
    endtask

    task automatic post_write(input logic [video_pkg::PAL_ADDR_W-1:0] addr,
                              input video_pkg::argb_t data);
        wr_cur.addr = addr;
        wr_cur.data = data;
        wr_pending  = 1'b1;
    endtask

    // de_pct is the chance of a visible pixel while the write waits
    task automatic wait_write(input int de_pct);
        while (wr_pending) begin
            if (rand_below(100) < de_pct) begin
                step(visible_pixel());
            end else begin
                step(blank_pixel());
            end
        end
    endtask

    task automatic load_palette();
        for (int i = 0; i < video_pkg::PAL_DEPTH; i++) begin
            post_write(i[8:0], rand_argb());
            wait_write(0);
            repeat (rand_below(3)) step(blank_pixel()); // random gaps
        end
    endtask

    task automatic rewrite_during_lines();
        logic [15:0] v;
        for (int i = 0; i < REWRITES; i++) begin
            v = rand16();
            post_write(v[8:0], rand_argb());
            wait_write(50);                             // held across visible pixels
            repeat (rand_below(3)) step(visible_pixel());
        end
    endtask

    task automatic directed_blend();
        for (int i = 0; i < 10; i++) begin
            post_write({1'b0, 8'(i)}, video_pkg::argb_t'(DIR_A[i]));
            wait_write(0);
            post_write({1'b1, 8'(i)}, video_pkg::argb_t'(DIR_B[i]));
            wait_write(0);
        end
        for (int i = 0; i < 20; i++) begin
            step(make_pixel(1'b0, 1'b0, 1'b1, 8'(i % 10), 8'(i % 10)));
        end
        repeat (8) step(blank_pixel());
    endtask

    task automatic random_lines(input int n);
        for (int ln = 0; ln < n; ln++) begin
            for (int x = 0; x < LINE_ACTIVE; x++) begin
                step(make_pixel(1'b0, ln == 0, 1'b1, rand_idx(), rand_idx()));
            end
            for (int x = 0; x < LINE_BLANK; x++) begin
                step(make_pixel(x >= 4 && x < 10, ln == 0, 1'b0, rand_idx(), rand_idx()));
            end
        end
    endtask

    task automatic random_timing_lines(input int n);
        logic [15:0] v;
        repeat (n * LINE_LEN) begin
            v = rand16();
            step(make_pixel(v[0], v[1], v[2], rand_idx(), rand_idx()));
        end
    endtask

    // entry k of table A changes in the gap between two lines
    task automatic frame_rewrite();
        logic [video_pkg::PAL_IDX_W-1:0] k;
        logic [15:0]                     v;
        k = rand_idx();
        v = rand16();
        post_write({1'b0, k}, video_pkg::argb_t'({4'hc, v[11:0]})); // A on top
        wait_write(0);
        repeat (3) step(blank_pixel());
        repeat (LINE_ACTIVE) step(make_pixel(1'b0, 1'b0, 1'b1, k, rand_idx()));
        post_write({1'b0, k}, video_pkg::argb_t'({4'hc, ~v[11:0]}));  // every bit differs
        wait_write(0);
        repeat (LINE_ACTIVE) step(make_pixel(1'b0, 1'b0, 1'b1, k, rand_idx()));
        repeat (LINE_BLANK) step(blank_pixel());
    endtask

    // scoreboard
    always @(posedge clk) begin
        if (check_en) begin
            if (exp_q.size() >= 4) begin
                exp_pix = exp_q.pop_front();
                check_equal("pix_o.timing", {29'd0, pix_o.timing}, {29'd0, exp_pix.timing});
                check_equal("pix_o.rgb", {20'd0, pix_o.rgb}, {20'd0, exp_pix.rgb});
            end else begin
                check_equal("pix_o", {17'd0, pix_o}, 32'h0); // still flushing reset
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("tests failed");
            $fatal(1, "timeout, no verdict after %0d cycles", cycle_cnt);
        end
    end

    initial begin
        rst_n_i        = 1'b0;
        pix_i          = '0;
        pal_wr_valid_i = 1'b0;
        pal_wr_i       = '0;
        wr_pending     = 1'b0;
        wr_cur         = '0;
        staged_v       = 1'b0;
        staged         = '0;
        check_en       = 1'b0;
        repeat (16) @(negedge clk);
        rst_n_i  = 1'b1;
        check_en = 1'b1;

        load_palette();
        rewrite_during_lines();
        directed_blend();
        random_lines(RAND_LINES);
        random_timing_lines(TIMING_LINES);
        frame_rewrite();
        repeat (4) step(blank_pixel()); // drain the pipeline
        @(posedge clk);
        @(negedge clk);

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== rtl/compositor_top.sv ====
`timescale 1ns/1ps

module compositor_top (
    input  logic                  clk,
    input  logic                  rst_n_i,

    // pixel stream from the playfields, one per clock
    input  video_pkg::pixel_in_t  pix_i,

    // host palette port
    input  logic                  pal_wr_valid_i,
    input  video_pkg::pal_wr_t    pal_wr_i,
    output logic                  pal_wr_ready_o,

    // composited pixel, 3 cycles after pix_i
    output video_pkg::pixel_out_t pix_o
);

    logic               ram_we;
    video_pkg::pal_wr_t ram_wr;

    video_pkg::argb_t   color_a;
    video_pkg::argb_t   color_b;
    video_pkg::timing_t ram_timing;   // timing after lookup

    video_pkg::rgb_t    blend_rgb;
    video_pkg::timing_t blend_timing; // timing after blend

    palette_writer u_palette_writer (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pal_wr_valid_i (pal_wr_valid_i),
        .pal_wr_i       (pal_wr_i),
        .de_i           (pix_i.timing.de),
        .pal_wr_ready_o (pal_wr_ready_o),
        .ram_we_o       (ram_we),
        .ram_wr_o       (ram_wr)
    );

    palette_ram u_palette_ram (
        .clk       (clk),
        .we_i      (ram_we),
        .wr_i      (ram_wr),
        .pix_i     (pix_i),
        .color_a_o (color_a),
        .color_b_o (color_b),
        .timing_o  (ram_timing)
    );

    video_blend u_video_blend (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .color_a_i (color_a),
        .color_b_i (color_b),
        .timing_i  (ram_timing),
        .rgb_o     (blend_rgb),
        .timing_o  (blend_timing)
    );

    video_out u_video_out (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .rgb_i    (blend_rgb),
        .timing_i (blend_timing),
        .pix_o    (pix_o)
    );

endmodule

// ==== rtl/video_out.sv ====
`timescale 1ns/1ps

module video_out (
    input  logic                  clk,
    input  logic                  rst_n_i,

    // blended color with its timing
    input  video_pkg::rgb_t       rgb_i,
    input  video_pkg::timing_t    timing_i,

    // outgoing pixel, straight from flops
    output video_pkg::pixel_out_t pix_o
);

    video_pkg::rgb_t rgb_blanked;

    // black outside the visible area
    always_comb begin
        if (timing_i.de) begin
            rgb_blanked = rgb_i;
        end else begin
            rgb_blanked = '0;
        end
    end

    // color and sync leave on the same edge
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pix_o <= '0;    // sync low, color black
        end else begin
            pix_o.timing <= timing_i;
            pix_o.rgb    <= rgb_blanked;
        end
    end

endmodule

// ==== rtl/video_blend.sv ====
`timescale 1ns/1ps

module video_blend (
    input  logic               clk,
    input  logic               rst_n_i,

    // colors from the palette lookup
    input  video_pkg::argb_t   color_a_i,
    input  video_pkg::argb_t   color_b_i,
    input  video_pkg::timing_t timing_i,

    // blended color and matching timing, one cycle later
    output video_pkg::rgb_t    rgb_o,
    output video_pkg::timing_t timing_o
);

    video_pkg::blend_mode_e mode;     // rule chosen by A
    logic [1:0]             b_amount; // share of B in B-alpha mode
    video_pkg::rgb_t        blend_rgb;

    // one channel of the blend
    function automatic logic [3:0] blend_chan(
        input video_pkg::blend_mode_e mode_i,
        input logic [1:0]             amount_i,
        input logic [3:0]             a_i,
        input logic [3:0]             b_i
    );
        logic [5:0] sum_75; // a + 2a + b
        logic [4:0] sum;    // a + b, carry kept
        logic [3:0] res;

        sum_75 = {2'b00, a_i} + {1'b0, a_i, 1'b0} + {2'b00, b_i};
        sum    = {1'b0, a_i} + {1'b0, b_i};

        case (mode_i)
            video_pkg::BLEND_B_ALPHA: begin
                case (amount_i)
                    2'b00:   res = a_i;          // 100% A
                    2'b01:   res = sum_75[5:2];  // 75% A, 25% B
                    2'b10:   res = sum[4:1];     // 50/50
                    default: res = b_i;          // 100% B
                endcase
            end
            video_pkg::BLEND_WRAP: begin
                res = sum[3:0];                  // carry dropped
            end
            video_pkg::BLEND_CLAMP: begin
                // saturate on any overflow, not just when both msbs set
                res = sum[4] ? 4'hf : sum[3:0];
            end
            default: begin
                res = a_i;                       // A on top, B ignored
            end
        endcase

        return res;
    endfunction

    assign mode     = video_pkg::blend_mode_e'(color_a_i.alpha[3:2]);
    assign b_amount = color_b_i.alpha[3:2];

    always_comb begin
        blend_rgb.r = blend_chan(mode, b_amount, color_a_i.rgb.r, color_b_i.rgb.r);
        blend_rgb.g = blend_chan(mode, b_amount, color_a_i.rgb.g, color_b_i.rgb.g);
        blend_rgb.b = blend_chan(mode, b_amount, color_a_i.rgb.b, color_b_i.rgb.b);
    end

    // timing is control, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            timing_o <= '0;
        end else begin
            timing_o <= timing_i;
        end
    end

    // color payload, blanking is applied at the output stage
    always_ff @(posedge clk) begin
        rgb_o <= blend_rgb;
    end

endmodule

// ==== rtl/palette_ram.sv ====
`timescale 1ns/1ps

module palette_ram (
    input  logic                  clk,

    // write port from the palette writer
    input  logic                  we_i,
    input  video_pkg::pal_wr_t    wr_i,

    // pixel indices and timing, every clock
    input  video_pkg::pixel_in_t  pix_i,

    // registered colors, one cycle after pix_i
    output video_pkg::argb_t      color_a_o,
    output video_pkg::argb_t      color_b_o,
    output video_pkg::timing_t    timing_o
);

    // table A at 0..255, table B at 256..511
    video_pkg::argb_t mem [video_pkg::PAL_DEPTH];

    logic [video_pkg::PAL_ADDR_W-1:0] addr_a;
    logic [video_pkg::PAL_ADDR_W-1:0] addr_b;

    assign addr_a = {1'b0, pix_i.idx_a};
    assign addr_b = {1'b1, pix_i.idx_b};

    // single write port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // two registered read ports
    // a read on the same edge as a write returns the old entry
    always_ff @(posedge clk) begin
        color_a_o <= mem[addr_a];
        color_b_o <= mem[addr_b];
    end

    // timing follows the lookup so sync stays with its colors
    always_ff @(posedge clk) begin
        timing_o <= pix_i.timing;
    end

endmodule

// ==== rtl/palette_writer.sv ====
`timescale 1ns/1ps

module palette_writer (
    input  logic              clk,
    input  logic              rst_n_i,

    // host side
    input  logic              pal_wr_valid_i,
    input  video_pkg::pal_wr_t pal_wr_i,
    output logic              pal_wr_ready_o,

    // display enable of the incoming pixel
    input  logic              de_i,

    // palette RAM write port
    output logic              ram_we_o,
    output video_pkg::pal_wr_t ram_wr_o
);

    logic accept; // handshake completes on this edge

    // only take writes during blanking, so the visible area never
    // sees a palette entry change under it
    assign pal_wr_ready_o = ~de_i;
    assign accept         = pal_wr_valid_i & pal_wr_ready_o;

    // write strobe is high for exactly one cycle per accepted write
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ram_we_o <= 1'b0;
        end else begin
            ram_we_o <= accept;
        end
    end

    // address and data only need to be valid with the strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            ram_wr_o <= pal_wr_i;
        end
    end

endmodule

// ==== rtl/video_pkg.sv ====
package video_pkg;

    // palette geometry
    localparam int PAL_IDX_W  = 8;               // color index from each playfield
    localparam int PAL_ADDR_W = PAL_IDX_W + 1;   // top bit picks table A or table B
    localparam int PAL_DEPTH  = 1 << PAL_ADDR_W; // both tables together

    // 12-bit color, 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // palette entry
    // alpha[3:2] selects the blend mode when this is color A,
    // alpha[3:2] of color B sets the mix amount in B-alpha mode
    typedef struct packed {
        logic [3:0] alpha;
        rgb_t       rgb;
    } argb_t;

    // blend rule, taken from alpha[3:2] of color A
    typedef enum logic [1:0] {
        BLEND_B_ALPHA = 2'b00, // mix by B's alpha
        BLEND_WRAP    = 2'b01, // add, wrap at 16
        BLEND_CLAMP   = 2'b10, // add, saturate at 15
        BLEND_A_TOP   = 2'b11  // A only
    } blend_mode_e;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;    // display enable
    } timing_t;

    // one pixel from the two playfield pipelines
    typedef struct packed {
        timing_t              timing;
        logic [PAL_IDX_W-1:0] idx_a;
        logic [PAL_IDX_W-1:0] idx_b;
    } pixel_in_t;

    // host write into the palette
    typedef struct packed {
        logic [PAL_ADDR_W-1:0] addr;
        argb_t                 data;
    } pal_wr_t;

    // pixel leaving the compositor
    typedef struct packed {
        timing_t timing;
        rgb_t    rgb;
    } pixel_out_t;

endpackage
